// File: run.sh
#!/bin/sh
# build and run the SPC core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf build
verilator --binary --timing -f sources.f --top-module tb_spc_core --Mdir build -o tb_spc_core
./build/tb_spc_core 2>&1 | tee build/sim.log
if grep -q "^TEST OK$" build/sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: source/spc_alu.sv
// Eight-operation ALU
`timescale 1ns/1ps
`default_nettype none

module spc_alu import spc_pkg::*; (
	input alu_op_t op,
	input byte_t a,
	input byte_t b,
	output byte_t result,
	output logic zero
);

	always_comb begin
		case (op)
			alu_or: result = a | b;
			alu_and: result = a & b;
			alu_xor: result = a ^ b;
			alu_andnot: result = a & ~b;
			// sum and difference wrap at 8 bits, no carry in
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_pass_a: result = a;
			default: result = b;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/spc_core.sv
// SPC CPU core top
`timescale 1ns/1ps
`default_nettype none

module spc_core import spc_pkg::*; (
	input logic clock,
	input logic reset,
	output addr_t ram_address,
	input byte_t ram_read,
	output logic halted
);

	// sequencer to ALU
	alu_op_t alu_op;
	byte_t alu_a;
	byte_t alu_b;
	byte_t alu_result;
	logic alu_zero;

	// sequencer to register file
	reg_index_t read_index;
	byte_t read_data;
	logic write_enable;
	reg_index_t write_index;
	byte_t write_data;
	logic status_enable;
	psw_t status_mask;
	psw_t status_value;
	psw_t psw;

	spc_uop_if uop_bus ();

	spc_decoder u_decoder (
		.ram_read (ram_read),
		.uop (uop_bus.decoder)
	);

	spc_alu u_alu (
		.op (alu_op),
		.a (alu_a),
		.b (alu_b),
		.result (alu_result),
		.zero (alu_zero)
	);

	spc_register_file u_register_file (
		.clock (clock),
		.reset (reset),
		.read_index (read_index),
		.read_data (read_data),
		.write_enable (write_enable),
		.write_index (write_index),
		.write_data (write_data),
		.status_enable (status_enable),
		.status_mask (status_mask),
		.status_value (status_value),
		.psw (psw)
	);

	spc_sequencer u_sequencer (
		.clock (clock),
		.reset (reset),
		.uop (uop_bus.sequencer),
		.ram_read (ram_read),
		.ram_address (ram_address),
		.halted (halted),
		.alu_op (alu_op),
		.alu_a (alu_a),
		.alu_b (alu_b),
		.alu_result (alu_result),
		.alu_zero (alu_zero),
		.read_index (read_index),
		.read_data (read_data),
		.write_enable (write_enable),
		.write_index (write_index),
		.write_data (write_data),
		.status_enable (status_enable),
		.status_mask (status_mask),
		.status_value (status_value),
		.psw (psw)
	);

endmodule

`default_nettype wire

// File: source/spc_decoder.sv
// Opcode decoder
`timescale 1ns/1ps
`default_nettype none

module spc_decoder import spc_pkg::*; (
	input byte_t ram_read,
	spc_uop_if.decoder uop
);

	// opcode splits as row[7:5], column[4:2], set[1:0]
	logic [2:0] row;

	assign row = ram_read[7:5];

	always_comb begin
		// defaults describe a one-byte instruction with no side effects
		uop.alu_op = alu_pass_a;
		uop.a_sel = operand_register;
		uop.b_sel = operand_register;
		uop.a_index = reg_a;
		uop.a_const = '0;
		uop.b_const = '0;
		uop.result_index = reg_a;
		uop.write_back = 1'b0;
		uop.status_mask = '0;
		uop.status_value = '0;
		uop.branch = 1'b0;
		uop.two_byte = 1'b0;
		uop.illegal = 1'b0;

		case (ram_read[4:0])
			// status control column
			5'b000_00: begin
				case (row)
					3'd1: uop.status_mask[psw_p] = 1'b1;
					3'd2: begin
						uop.status_mask[psw_p] = 1'b1;
						uop.status_value[psw_p] = 1'b1;
					end
					3'd3: uop.status_mask[psw_c] = 1'b1;
					3'd4: begin
						uop.status_mask[psw_c] = 1'b1;
						uop.status_value[psw_c] = 1'b1;
					end
					3'd5: uop.status_mask[psw_i] = 1'b1;
					3'd6: begin
						uop.status_mask[psw_i] = 1'b1;
						uop.status_value[psw_i] = 1'b1;
					end
					3'd7: uop.status_mask[psw_v] = 1'b1;
					// NOP leaves every flag alone
					default: uop.status_mask = '0;
				endcase
			end

			// relative branches, taken when mask op psw gives zero
			5'b100_00: begin
				uop.branch = 1'b1;
				uop.two_byte = 1'b1;
				uop.a_sel = operand_constant;
				// operand b register source is the status word
				uop.b_sel = operand_register;
				// odd rows test for a set flag
				uop.alu_op = row[0] ? alu_andnot : alu_and;
				case (row[2:1])
					2'd0: uop.a_const[psw_n] = 1'b1;
					2'd1: uop.a_const[psw_v] = 1'b1;
					2'd2: uop.a_const[psw_c] = 1'b1;
					default: uop.a_const[psw_z] = 1'b1;
				endcase
			end

			// immediate arithmetic and logic on A
			5'b010_00: begin
				uop.two_byte = 1'b1;
				uop.b_sel = operand_fetched;
				uop.write_back = 1'b1;
				uop.status_mask[psw_z] = 1'b1;
				case (row)
					3'd0: uop.alu_op = alu_or;
					3'd1: uop.alu_op = alu_and;
					3'd2: uop.alu_op = alu_xor;
					// CMP only sets Z
					3'd3: begin
						uop.alu_op = alu_sub;
						uop.write_back = 1'b0;
					end
					3'd4: uop.alu_op = alu_add;
					3'd5: uop.alu_op = alu_sub;
					// CPX compares X
					3'd6: begin
						uop.alu_op = alu_sub;
						uop.a_index = reg_x;
						uop.write_back = 1'b0;
					end
					// LDA passes the immediate through
					default: begin
						uop.alu_op = alu_pass_a;
						uop.a_sel = operand_fetched;
					end
				endcase
			end

			default: uop.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: source/spc_pkg.sv
// SPC core shared definitions
`default_nettype none

package spc_pkg;

	// 16-bit address space, shared by memory and program counter
	typedef logic [15:0] addr_t;
	// data bytes, registers and immediates
	typedef logic [7:0] byte_t;
	typedef logic [7:0] psw_t;
	typedef logic [1:0] reg_index_t;

	// register file slots
	localparam reg_index_t reg_a = 2'd0;
	localparam reg_index_t reg_x = 2'd1;
	localparam reg_index_t reg_y = 2'd2;
	localparam reg_index_t reg_sp = 2'd3;

	// status word bit positions, N sits in bit 0 and C in bit 7
	localparam int unsigned psw_n = 0;
	localparam int unsigned psw_v = 1;
	localparam int unsigned psw_p = 2;
	localparam int unsigned psw_b = 3;
	localparam int unsigned psw_h = 4;
	localparam int unsigned psw_i = 5;
	localparam int unsigned psw_z = 6;
	localparam int unsigned psw_c = 7;

	typedef enum logic [2:0] {
		alu_or, alu_and, alu_xor, alu_andnot,
		alu_add, alu_sub, alu_pass_a, alu_pass_b
	} alu_op_t;

	// where an ALU operand comes from
	typedef enum logic [1:0] {
		operand_register, operand_constant, operand_fetched
	} operand_sel_t;

	typedef enum logic [2:0] {
		stage_fetch, stage_decode, stage_param,
		stage_execute, stage_writeback, stage_halt
	} stage_t;

endpackage

`default_nettype wire

// File: source/spc_register_file.sv
// Register file and status word
`timescale 1ns/1ps
`default_nettype none

module spc_register_file import spc_pkg::*; (
	input logic clock,
	input logic reset,
	input reg_index_t read_index,
	output byte_t read_data,
	input logic write_enable,
	input reg_index_t write_index,
	input byte_t write_data,
	input logic status_enable,
	input psw_t status_mask,
	input psw_t status_value,
	output psw_t psw
);

	// A, X, Y and SP
	byte_t regs [4];

	// single asynchronous read port
	assign read_data = regs[read_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			regs[reg_a] <= '0;
			regs[reg_x] <= '0;
			regs[reg_y] <= '0;
			regs[reg_sp] <= '0;
			psw <= '0;
		end else begin
			if (write_enable) begin
				regs[write_index] <= write_data;
			end
			// only the masked flags move
			if (status_enable) begin
				psw <= (psw & ~status_mask) | (status_value & status_mask);
			end
		end
	end

endmodule

`default_nettype wire

// File: source/spc_sequencer.sv
// Instruction stage sequencer
`timescale 1ns/1ps
`default_nettype none

module spc_sequencer import spc_pkg::*; (
	input logic clock,
	input logic reset,
	spc_uop_if.sequencer uop,
	input byte_t ram_read,
	output addr_t ram_address,
	output logic halted,
	output alu_op_t alu_op,
	output byte_t alu_a,
	output byte_t alu_b,
	input byte_t alu_result,
	input logic alu_zero,
	output reg_index_t read_index,
	input byte_t read_data,
	output logic write_enable,
	output reg_index_t write_index,
	output byte_t write_data,
	output logic status_enable,
	output psw_t status_mask,
	output psw_t status_value,
	input psw_t psw
);

	stage_t stage;
	addr_t pc;

	// micro-operation held from decode to write-back
	alu_op_t op_q;
	operand_sel_t a_sel_q;
	operand_sel_t b_sel_q;
	reg_index_t a_index_q;
	byte_t a_const_q;
	byte_t b_const_q;
	reg_index_t result_index_q;
	logic write_back_q;
	psw_t mask_q;
	psw_t value_q;
	logic branch_q;
	logic two_byte_q;

	// datapath registers
	byte_t imm_q;
	byte_t operand_a;
	byte_t operand_b;
	byte_t result_q;
	logic zero_q;

	byte_t a_value;
	byte_t b_value;
	addr_t next_pc;
	addr_t branch_target;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage <= stage_fetch;
			pc <= '0;
		end else begin
			case (stage)
				stage_fetch: stage <= stage_decode;
				// illegal opcode freezes the core at its own address
				stage_decode: stage <= uop.illegal ? stage_halt : stage_param;
				stage_param: stage <= stage_execute;
				stage_execute: stage <= stage_writeback;
				stage_writeback: begin
					stage <= stage_fetch;
					pc <= (branch_q && zero_q) ? branch_target : next_pc;
				end
				default: stage <= stage_halt;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (stage == stage_decode) begin
			op_q <= uop.alu_op;
			a_sel_q <= uop.a_sel;
			b_sel_q <= uop.b_sel;
			a_index_q <= uop.a_index;
			a_const_q <= uop.a_const;
			b_const_q <= uop.b_const;
			result_index_q <= uop.result_index;
			write_back_q <= uop.write_back;
			mask_q <= uop.status_mask;
			value_q <= uop.status_value;
			branch_q <= uop.branch;
			two_byte_q <= uop.two_byte;
		end
		// immediate byte is on the bus during param
		if (stage == stage_param) begin
			imm_q <= ram_read;
			operand_a <= a_value;
			operand_b <= b_value;
		end
		if (stage == stage_execute) begin
			result_q <= alu_result;
			zero_q <= alu_zero;
		end
	end

	// operand muxes, resolved in param
	always_comb begin
		case (a_sel_q)
			operand_constant: a_value = a_const_q;
			operand_fetched: a_value = ram_read;
			default: a_value = read_data;
		endcase
		// b has no register port, its register source is the status word
		case (b_sel_q)
			operand_constant: b_value = b_const_q;
			operand_fetched: b_value = ram_read;
			default: b_value = psw;
		endcase
	end

	// opcode address while fetching or halted, immediate address otherwise
	assign ram_address = (stage == stage_fetch || stage == stage_decode
		|| stage == stage_halt) ? pc : pc + 16'd1;

	assign next_pc = pc + (two_byte_q ? 16'd2 : 16'd1);
	// offset is relative to the following instruction
	assign branch_target = next_pc + {{8{imm_q[7]}}, imm_q};

	assign read_index = a_index_q;
	assign alu_op = op_q;
	assign alu_a = operand_a;
	assign alu_b = operand_b;

	assign write_enable = (stage == stage_writeback) && write_back_q;
	assign write_index = result_index_q;
	assign write_data = result_q;

	assign status_enable = (stage == stage_writeback);
	assign status_mask = mask_q;

	// Z follows the ALU whenever the instruction updates it
	always_comb begin
		status_value = value_q;
		if (mask_q[psw_z]) begin
			status_value[psw_z] = zero_q;
		end
	end

	assign halted = (stage == stage_halt);

endmodule

`default_nettype wire

// File: source/spc_uop_if.sv
// Decoded instruction bundle
`timescale 1ns/1ps
`default_nettype none

interface spc_uop_if import spc_pkg::*; ();

	alu_op_t alu_op;
	operand_sel_t a_sel;
	operand_sel_t b_sel;
	reg_index_t a_index;
	byte_t a_const;
	byte_t b_const;
	reg_index_t result_index;
	// result goes back to result_index
	logic write_back;
	// flags touched, and the values they take
	psw_t status_mask;
	psw_t status_value;
	logic branch;
	// instruction carries an immediate byte
	logic two_byte;
	logic illegal;

	modport decoder (
		output alu_op, a_sel, b_sel, a_index, a_const, b_const, result_index,
		write_back, status_mask, status_value, branch, two_byte, illegal
	);

	modport sequencer (
		input alu_op, a_sel, b_sel, a_index, a_const, b_const, result_index,
		write_back, status_mask, status_value, branch, two_byte, illegal
	);

endinterface

`default_nettype wire

// File: sources.f
+incdir+verification
source/spc_pkg.sv
source/spc_uop_if.sv
source/spc_decoder.sv
source/spc_alu.sv
source/spc_register_file.sv
source/spc_sequencer.sv
source/spc_core.sv
verification/tb_spc_core.sv

// File: verification/tb_spc_model.svh
// SPC core reference model
`ifndef TB_SPC_MODEL_SVH
`define TB_SPC_MODEL_SVH

// low five opcode bits pick the column, high three the row
localparam logic [4:0] col_status = 5'h00;
localparam logic [4:0] col_immediate = 5'h08;
localparam logic [4:0] col_branch = 5'h10;

localparam byte_t op_nop = 8'h00;
localparam byte_t op_clp = 8'h20;
localparam byte_t op_sep = 8'h40;
localparam byte_t op_clc = 8'h60;
localparam byte_t op_sec = 8'h80;
localparam byte_t op_cli = 8'ha0;
localparam byte_t op_sei = 8'hc0;
localparam byte_t op_clv = 8'he0;
localparam byte_t op_bpl = 8'h10;
localparam byte_t op_bvc = 8'h50;
localparam byte_t op_bvs = 8'h70;
localparam byte_t op_bcc = 8'h90;
localparam byte_t op_bcs = 8'hb0;
localparam byte_t op_bne = 8'hd0;
localparam byte_t op_beq = 8'hf0;

// architectural state as the programmer sees it
addr_t model_pc;
byte_t model_regs [4];
psw_t model_psw;

task automatic model_reset();
	model_pc = 16'h0000;
	model_regs[reg_a] = 8'h00;
	model_regs[reg_x] = 8'h00;
	model_regs[reg_y] = 8'h00;
	model_regs[reg_sp] = 8'h00;
	model_psw = 8'h00;
endtask

// only the status column is one byte long
function automatic addr_t instruction_length(input byte_t opcode);
	return (opcode[4:0] == col_status) ? 16'd1 : 16'd2;
endfunction

task automatic model_execute(input byte_t opcode, input byte_t imm);
	logic [2:0] row;
	logic flag;
	byte_t result;
	addr_t next_pc;
	row = opcode[7:5];
	next_pc = model_pc + instruction_length(opcode);
	case (opcode[4:0])
		col_status: begin
			case (row)
				3'd1: model_psw[psw_p] = 1'b0;
				3'd2: model_psw[psw_p] = 1'b1;
				3'd3: model_psw[psw_c] = 1'b0;
				3'd4: model_psw[psw_c] = 1'b1;
				3'd5: model_psw[psw_i] = 1'b0;
				3'd6: model_psw[psw_i] = 1'b1;
				3'd7: model_psw[psw_v] = 1'b0;
				default: model_psw = model_psw;
			endcase
		end
		col_branch: begin
			case (row[2:1])
				2'd0: flag = model_psw[psw_n];
				2'd1: flag = model_psw[psw_v];
				2'd2: flag = model_psw[psw_c];
				default: flag = model_psw[psw_z];
			endcase
			// even rows jump on a clear flag, odd rows on a set one
			if (flag == row[0]) begin
				next_pc = next_pc + {{8{imm[7]}}, imm};
			end
		end
		default: begin
			case (row)
				3'd0: result = model_regs[reg_a] | imm;
				3'd1: result = model_regs[reg_a] & imm;
				3'd2: result = model_regs[reg_a] ^ imm;
				3'd3: result = model_regs[reg_a] - imm;
				3'd4: result = model_regs[reg_a] + imm;
				3'd5: result = model_regs[reg_a] - imm;
				3'd6: result = model_regs[reg_x] - imm;
				default: result = imm;
			endcase
			// compares keep A
			if (row != 3'd3 && row != 3'd6) begin
				model_regs[reg_a] = result;
			end
			model_psw[psw_z] = (result == 8'h00);
		end
	endcase
	model_pc = next_pc;
endtask

// immediate that drives the result of an ALU opcode to zero
function automatic byte_t zero_immediate(input byte_t opcode);
	case (opcode[7:5])
		3'd2, 3'd3, 3'd5: return model_regs[reg_a];
		3'd4: return 8'h00 - model_regs[reg_a];
		3'd6: return model_regs[reg_x];
		// ORA only reaches zero when A already is
		default: return 8'h00;
	endcase
endfunction

task automatic random_instruction(output byte_t opcode, output byte_t imm);
	byte_t column;
	byte_t row;
	column = random_bits(2);
	row = random_bits(3);
	imm = random_bits(8);
	case (column[1:0])
		2'd0: opcode = {row[2:0], col_status};
		2'd1: begin
			opcode = {row[2:0], col_branch};
			// forward offsets keep the walk on fresh memory
			imm[7] = 1'b0;
		end
		default: opcode = {row[2:0], col_immediate};
	endcase
endtask

`endif

// File: verification/tb_spc_core.sv
// SPC core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_spc_core import spc_pkg::*; ();

	logic clock;
	logic reset;
	addr_t ram_address;
	byte_t ram_read;
	logic halted;

	// 64 KB program memory, answers in the same cycle
	byte_t mem [65536];
	logic [31:0] lfsr_state;

	assign ram_read = mem[ram_address];

	spc_core u_spc_core (
		.clock (clock),
		.reset (reset),
		.ram_address (ram_address),
		.ram_read (ram_read),
		.halted (halted)
	);

	always #5 clock = ~clock;

	// taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// one LFSR step per returned bit
	function automatic byte_t random_bits(input int count);
		byte_t value;
		value = 8'h00;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
		return value;
	endfunction

	`include "tb_spc_model.svh"

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			stop_with_failure();
		end
	endtask

	// sampled in the fetch cycle, after write-back has landed
	task automatic check_state();
		check_value("halted", {15'd0, halted}, 16'h0000);
		check_value("ram_address", ram_address, model_pc);
		check_value("a", {8'h00, u_spc_core.u_register_file.regs[reg_a]},
			{8'h00, model_regs[reg_a]});
		check_value("x", {8'h00, u_spc_core.u_register_file.regs[reg_x]},
			{8'h00, model_regs[reg_x]});
		check_value("psw", {8'h00, u_spc_core.u_register_file.psw}, {8'h00, model_psw});
	endtask

	// place one instruction at the fetch address and let it run its five stages
	task automatic run_instruction(input byte_t opcode, input byte_t imm);
		check_state();
		mem[model_pc] = opcode;
		if (instruction_length(opcode) == 16'd2) begin
			mem[model_pc + 16'd1] = imm;
		end
		model_execute(opcode, imm);
		repeat (5) @(posedge clock);
		#1;
	endtask

	initial begin
		byte_t opcode;
		byte_t imm;
		int unsigned wait_cycles;
		clock = 1'b0;
		reset = 1'b1;
		lfsr_state = 32'h15d2_6a52;
		for (int i = 0; i < 65536; i++) begin
			mem[i[15:0]] = byte_t'(i[7:0] ^ i[15:8] ^ 8'ha5);
		end
		model_reset();
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		// N stays clear, so BPL always jumps, here once backwards into a gap
		run_instruction(op_bpl, 8'h10);
		run_instruction(op_bpl, 8'hee);
		run_instruction(op_bpl, 8'h20);

		// flag set and clear, seen through branches and the status word
		run_instruction(op_sec, 8'h00);
		run_instruction(op_bcs, 8'h05);
		run_instruction(op_clc, 8'h00);
		run_instruction(op_bcs, 8'h05);
		run_instruction(op_bcc, 8'h03);
		run_instruction(op_sep, 8'h00);
		run_instruction(op_clp, 8'h00);
		run_instruction(op_sei, 8'h00);
		run_instruction(op_cli, 8'h00);
		run_instruction(op_clv, 8'h00);
		run_instruction(op_bvs, 8'h09);
		run_instruction(op_bvc, 8'h07);
		run_instruction(op_nop, 8'h00);

		// each ALU row with a random immediate, then with one that gives zero
		for (int round = 0; round < 2; round++) begin
			for (int row = 0; row < 8; row++) begin
				opcode = {row[2:0], col_immediate};
				imm = (round == 0) ? random_bits(8) : zero_immediate(opcode);
				run_instruction(opcode, imm);
				opcode = (random_bits(1) == 8'h01) ? op_beq : op_bne;
				run_instruction(opcode, random_bits(6));
			end
		end

		for (int n = 0; n < 300; n++) begin
			random_instruction(opcode, imm);
			run_instruction(opcode, imm);
		end

		// bit 0 set lies outside all three kept columns
		check_state();
		opcode = random_bits(8);
		opcode[0] = 1'b1;
		mem[model_pc] = opcode;
		wait_cycles = 0;
		while (halted !== 1'b1) begin
			if (wait_cycles == 3) begin
				$display("halted did not rise within 3 cycles of the illegal opcode fetch");
				stop_with_failure();
			end
			@(posedge clock);
			#1;
			wait_cycles++;
		end
		for (int n = 0; n < 10; n++) begin
			@(posedge clock);
			#1;
			check_value("halted", {15'd0, halted}, 16'h0001);
			check_value("ram_address", ram_address, model_pc);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
